// ==== Makefile ====
# Verilator build and run of the execute slice testbench
# Any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal -j 0
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_clkgen.sv ====
//----------------------------------------
// Testbench clock and reset source
// 10 ns clock, reset held for 3 edges
//----------------------------------------

`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
  end

  // Released 1 ns after the third edge, in step with stimulus
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== dv/tb_exec_top.sv ====
//----------------------------------------
// Directed tests for the execute slice
// Reference register model and in-order commit checks
//----------------------------------------

`timescale 1ns/10ps

`include "exec_cfg.svh"

module tb_exec_top
  import exec_pkg::*;
();

  localparam int RESET_TIMEOUT = 20;
  localparam int RDY_TIMEOUT   = 100;   // Long enough for random back-pressure
  localparam int DRAIN_TIMEOUT = 500;
  localparam int STREAM_LEN    = 200;

  // One expected commit pushed at the input transfer
  typedef struct packed {
    addr_t    pc;
    seq_t     seq;
    reg_idx_t waddr;
    data_t    wdata;
  } commit_t;

  logic     clk;
  logic     rst;
  logic     in_val;
  logic     in_rdy;
  addr_t    in_pc;
  rv_uop    in_uop;
  reg_idx_t in_rs1;
  reg_idx_t in_rs2;
  data_t    in_imm;
  reg_idx_t in_waddr;
  logic     commit_val;
  logic     commit_rdy;
  addr_t    commit_pc;
  seq_t     commit_seq_num;
  reg_idx_t commit_waddr;
  data_t    commit_wdata;

  // Reference model state
  data_t    model_regs [`EXEC_NUM_REGS];   // Entry 0 stays zero
  commit_t  exp_q [$];
  seq_t     exp_seq;
  addr_t    next_pc;

  int       mismatches;
  int       failures;
  int       commits;
  int       cycle = 0;
  int       last_accept;    // Cycle of the latest input transfer
  seq_t     last_seq;
  logic     have_last;
  logic     stream_done;

  tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  exec_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .in_val         (in_val),
    .in_rdy         (in_rdy),
    .in_pc          (in_pc),
    .in_uop         (in_uop),
    .in_rs1         (in_rs1),
    .in_rs2         (in_rs2),
    .in_imm         (in_imm),
    .in_waddr       (in_waddr),
    .commit_val     (commit_val),
    .commit_rdy     (commit_rdy),
    .commit_pc      (commit_pc),
    .commit_seq_num (commit_seq_num),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata)
  );

  always @(posedge clk) cycle <= cycle + 1;

  //----------------------------------------
  // Reporting
  //----------------------------------------

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    mismatches++;
  endtask

  task automatic flag_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    failures++;
  endtask

  task automatic finish_run();
    $display("errors %0d: %0d mismatches, %0d other failures, %0d commits checked",
             mismatches + failures, mismatches, failures, commits);
    if (mismatches + failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  //----------------------------------------
  // Reference model
  //----------------------------------------

  function automatic data_t expected_result(input rv_uop uop, input data_t a, input data_t b);
    data_t r;
    case (uop)
      OP_ADD, OP_ADDI: r = a + b;
      OP_SUB:          r = a - b;
      OP_AND:          r = a & b;
      OP_OR:           r = a | b;
      OP_XOR:          r = a ^ b;
      OP_SLL:          r = a << b[4:0];   // Low 5 bits only
      OP_SRL:          r = a >> b[4:0];
      OP_SLT: begin
        // With opposite signs the negative one is smaller
        if (a[31] != b[31]) r = {31'd0, a[31]};
        else                r = {31'd0, (a < b)};
      end
      default:         r = '0;
    endcase
    return r;
  endfunction

  // Called at the negedge before an input transfer edge
  task automatic record_issue();
    commit_t e;
    data_t   a;
    data_t   b;
    a       = model_regs[in_rs1];
    b       = (in_uop == OP_ADDI) ? in_imm : model_regs[in_rs2];
    e.pc    = in_pc;
    e.seq   = exp_seq;
    e.waddr = in_waddr;
    e.wdata = expected_result(in_uop, a, b);
    exp_q.push_back(e);
    if (in_waddr != '0) model_regs[in_waddr] = e.wdata;
    exp_seq = exp_seq + seq_t'(1);   // Wraps after 31
  endtask

  //----------------------------------------
  // Stimulus helpers
  //----------------------------------------

  task automatic drive_uop(input rv_uop uop, input reg_idx_t rs1, input reg_idx_t rs2,
                           input data_t imm, input reg_idx_t waddr);
    in_val   = 1'b1;
    in_pc    = next_pc;
    in_uop   = uop;
    in_rs1   = rs1;
    in_rs2   = rs2;
    in_imm   = imm;
    in_waddr = waddr;
    next_pc  = next_pc + 32'd4;
  endtask

  // Holds the offer until in_rdy and drops in_val after the edge
  task automatic accept_uop();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!in_rdy && waited < RDY_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!in_rdy) begin
      flag_failure("in_rdy stayed low, micro-op was never accepted");
      finish_run();
    end else begin
      record_issue();
      last_accept = cycle;
      @(posedge clk);
      #1;
      in_val = 1'b0;
    end
  endtask

  task automatic send_uop(input rv_uop uop, input reg_idx_t rs1, input reg_idx_t rs2,
                          input data_t imm, input reg_idx_t waddr);
    drive_uop(uop, rs1, rs2, imm, waddr);
    accept_uop();
  endtask

  // Waits until every expected commit has been seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      flag_failure($sformatf("%0d micro-ops never committed", exp_q.size()));
      finish_run();
    end else begin
      @(posedge clk);
      #1;
    end
  endtask

  //----------------------------------------
  // Commit monitor
  //----------------------------------------

  // Sampled mid-cycle since the transfer lands on the next edge
  always @(negedge clk) begin : commit_monitor
    commit_t head;
    if (!rst && commit_val && commit_rdy) begin
      commits++;
      if (exp_q.size() == 0) begin
        flag_failure("commit seen with no micro-op outstanding");
      end else begin
        head = exp_q.pop_front();
        if (commit_wdata !== head.wdata)
          report_mismatch($sformatf("seq %0d wdata got %h expected %h",
                                    head.seq, commit_wdata, head.wdata));
        if (commit_pc !== head.pc)
          report_mismatch($sformatf("pc got %h expected %h", commit_pc, head.pc));
        if (commit_seq_num !== head.seq)
          report_mismatch($sformatf("seq got %0d expected %0d", commit_seq_num, head.seq));
        if (commit_waddr !== head.waddr)
          report_mismatch($sformatf("waddr got %0d expected %0d", commit_waddr, head.waddr));
      end
      if (have_last && commit_seq_num !== last_seq + seq_t'(1))
        report_mismatch($sformatf("seq %0d does not follow %0d", commit_seq_num, last_seq));
      last_seq  = commit_seq_num;
      have_last = 1'b1;
    end
  end

  //----------------------------------------
  // Directed tests
  //----------------------------------------

  task automatic check_reset();
    int waited;
    waited = 0;
    @(negedge clk);
    while (rst && waited < RESET_TIMEOUT) begin
      if (commit_val !== 1'b0) report_mismatch("commit_val high during reset");
      waited++;
      @(negedge clk);
    end
    if (rst) begin
      flag_failure("reset was never released");
      finish_run();
    end else begin
      if (commit_val !== 1'b0) report_mismatch("commit_val high right after reset");
      waited = 0;
      while (!in_rdy && waited < RDY_TIMEOUT) begin
        waited++;
        @(negedge clk);
      end
      if (!in_rdy) begin
        flag_failure("in_rdy never rose after reset");
        finish_run();
      end else begin
        @(posedge clk);
        #1;   // Back in step with stimulus
      end
    end
  endtask

  task automatic run_each_op();
    send_uop(OP_ADDI, 0, 0, $urandom(), 1);
    send_uop(OP_ADDI, 0, 0, $urandom(), 2);
    send_uop(OP_ADD,  1, 2, '0, 3);
    send_uop(OP_SUB,  1, 2, '0, 4);
    send_uop(OP_AND,  1, 2, '0, 5);
    send_uop(OP_OR,   1, 2, '0, 6);
    send_uop(OP_XOR,  1, 2, '0, 7);
    send_uop(OP_SLL,  1, 2, '0, 8);    // Upper bits of r2 must be ignored
    send_uop(OP_SRL,  1, 2, '0, 9);
    send_uop(OP_SLT,  1, 2, '0, 10);
    send_uop(OP_ADDI, 1, 0, $urandom(), 11);
    // Signed compare across the sign boundary
    send_uop(OP_ADDI, 0, 0, $urandom() | 32'h8000_0000, 1);
    send_uop(OP_ADDI, 0, 0, $urandom() & 32'h7fff_ffff, 2);
    send_uop(OP_SLT,  1, 2, '0, 12);   // Negative < positive
    send_uop(OP_SLT,  2, 1, '0, 13);
    wait_drain();
  endtask

  task automatic chain_dependent_adds();
    int prev;
    int i;
    send_uop(OP_ADDI, 0, 0, $urandom(), 14);
    send_uop(OP_ADDI, 0, 0, $urandom(), 15);
    // 40 links wrap the sequence tag
    for (i = 0; i < 40; i++) begin
      prev = last_accept;
      send_uop(OP_ADD, 14, 15, '0, 14);
      if (last_accept - prev < 2)
        flag_failure("dependent add accepted before its producer wrote back");
    end
    wait_drain();
  endtask

  task automatic hold_commit_backpressure();
    addr_t    h_pc;
    seq_t     h_seq;
    reg_idx_t h_waddr;
    data_t    h_wdata;
    int       start_commits;
    int       waited;
    int       k;
    start_commits = commits;
    commit_rdy    = 1'b0;
    send_uop(OP_ADDI, 0, 0, $urandom(), 16);   // Ends in the commit register
    send_uop(OP_ADDI, 0, 0, $urandom(), 17);   // Ends in the ALU buffer
    drive_uop(OP_ADDI, 0, 0, $urandom(), 18);  // Independent and blocked by the stall only
    waited = 0;
    @(negedge clk);
    while ((in_rdy || !commit_val) && waited < RDY_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (in_rdy || !commit_val) begin
      flag_failure("in_rdy never dropped with commit_rdy held low");
      finish_run();
    end else begin
      h_pc    = commit_pc;
      h_seq   = commit_seq_num;
      h_waddr = commit_waddr;
      h_wdata = commit_wdata;
      for (k = 0; k < 8; k++) begin
        @(negedge clk);
        if (!commit_val || commit_pc !== h_pc || commit_seq_num !== h_seq ||
            commit_waddr !== h_waddr || commit_wdata !== h_wdata)
          report_mismatch("commit outputs changed under back-pressure");
        if (in_rdy) report_mismatch("in_rdy high while the pipeline is full");
      end
      @(posedge clk);
      #1;
      commit_rdy = 1'b1;
      accept_uop();   // Blocked micro-op now goes in
      wait_drain();
      if (commits - start_commits != 3)
        report_mismatch($sformatf("%0d commits after release, expected 3",
                                  commits - start_commits));
    end
  endtask

  task automatic write_reg_zero();
    send_uop(OP_ADDI, 0, 0, $urandom(), 0);   // Reported but never stored
    send_uop(OP_ADD,  0, 0, '0, 19);
    send_uop(OP_ADDI, 0, 0, 32'h5, 0);
    send_uop(OP_OR,   0, 1, '0, 20);
    send_uop(OP_SUB,  1, 0, '0, 21);
    send_uop(OP_ADDI, 0, 0, 32'h7, 22);      // r0 as op1 still zero
    wait_drain();
  endtask

  task automatic stream_random_uops();
    int n;
    stream_done = 1'b0;
    fork
      begin
        for (n = 0; n < STREAM_LEN; n++) begin
          drive_uop(rv_uop'(4'($urandom_range(0, 8))), reg_idx_t'($urandom_range(0, 31)),
                    reg_idx_t'($urandom_range(0, 31)), $urandom(),
                    reg_idx_t'($urandom_range(0, 31)));
          accept_uop();
        end
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          commit_rdy = 1'($urandom_range(0, 1));   // New choice every cycle
          @(posedge clk);
          #1;
        end
      end
    join
    commit_rdy = 1'b1;
    wait_drain();
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial begin
    void'($urandom(32'haa62_13f9));
    in_val      = 1'b0;
    in_pc       = '0;
    in_uop      = OP_ADD;
    in_rs1      = '0;
    in_rs2      = '0;
    in_imm      = '0;
    in_waddr    = '0;
    commit_rdy  = 1'b1;
    mismatches  = 0;
    failures    = 0;
    commits     = 0;
    last_accept = 0;
    last_seq    = '0;
    have_last   = 1'b0;
    stream_done = 1'b0;
    exp_seq     = '0;
    next_pc     = 32'h0000_1000;
    for (int r = 0; r < `EXEC_NUM_REGS; r++) begin
      model_regs[r] = '0;   // Matches the cleared register file
    end

    check_reset();
    run_each_op();
    chain_dependent_adds();
    hold_commit_backpressure();
    write_reg_zero();
    stream_random_uops();
    finish_run();
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/exec_pkg.sv
rtl/reg_file.sv
rtl/issue_unit.sv
rtl/alu.sv
rtl/writeback_unit.sv
rtl/exec_top.sv
dv/tb_clkgen.sv
dv/tb_exec_top.sv

// ==== rtl/alu.sv ====
//----------------------------------------
// Execute stage with a one-entry buffer
// Loads from issue, result goes to writeback
//----------------------------------------

`timescale 1ns/10ps

module alu
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // From issue
  input  logic     d_val,
  output logic     d_rdy,
  input  addr_t    d_pc,
  input  seq_t     d_seq_num,
  input  data_t    d_op1,
  input  data_t    d_op2,
  input  reg_idx_t d_waddr,
  input  rv_uop    d_uop,

  // To writeback
  output logic     w_val,
  input  logic     w_rdy,
  output addr_t    w_pc,
  output seq_t     w_seq_num,
  output reg_idx_t w_waddr,
  output data_t    w_wdata
);

  //----------------------------------------
  // Input buffer
  //----------------------------------------

  logic     buf_val;
  addr_t    buf_pc;
  seq_t     buf_seq_num;
  data_t    buf_op1;
  data_t    buf_op2;
  reg_idx_t buf_waddr;
  rv_uop    buf_uop;
  logic     d_xfer;
  logic     w_xfer;

  assign d_xfer = d_val & d_rdy;
  assign w_xfer = w_val & w_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_val <= 1'b0;
    end else if (d_xfer) begin
      buf_val <= 1'b1;   // Reload covers a same-cycle drain
    end else if (w_xfer) begin
      buf_val <= 1'b0;
    end
  end

  // Payload only, valid bit qualifies it
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      buf_pc      <= d_pc;
      buf_seq_num <= d_seq_num;
      buf_op1     <= d_op1;
      buf_op2     <= d_op2;
      buf_waddr   <= d_waddr;
      buf_uop     <= d_uop;
    end
  end

  //----------------------------------------
  // Arithmetic
  //----------------------------------------

  always_comb begin
    case (buf_uop)
      OP_ADD:  w_wdata = buf_op1 + buf_op2;
      OP_SUB:  w_wdata = buf_op1 - buf_op2;
      OP_AND:  w_wdata = buf_op1 & buf_op2;
      OP_OR:   w_wdata = buf_op1 | buf_op2;
      OP_XOR:  w_wdata = buf_op1 ^ buf_op2;
      OP_SLL:  w_wdata = buf_op1 << buf_op2[4:0];
      OP_SRL:  w_wdata = buf_op1 >> buf_op2[4:0];
      OP_SLT:  w_wdata = ($signed(buf_op1) < $signed(buf_op2)) ? data_t'(1) : '0;
      OP_ADDI: w_wdata = buf_op1 + buf_op2;   // op2 is the immediate
      default: w_wdata = '0;
    endcase
  end

  // Accept when empty or when the entry leaves this cycle
  assign d_rdy     = w_rdy | ~buf_val;
  assign w_val     = buf_val;
  assign w_pc      = buf_pc;
  assign w_seq_num = buf_seq_num;
  assign w_waddr   = buf_waddr;

endmodule

// ==== rtl/exec_cfg.svh ====
//----------------------------------------
// Widths and sizes of the execute slice
// Include wherever a width or size is needed
//----------------------------------------

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath widths
`define EXEC_ADDR_BITS 32   // Program counter
`define EXEC_DATA_BITS 32   // Operands and results

// Sequence tag width, wraps at 32
`define EXEC_SEQ_BITS  5

// Architectural register count, index is 5 bits
`define EXEC_NUM_REGS  32

`endif

// ==== rtl/exec_pkg.sv ====
//----------------------------------------
// Shared types of the execute slice
// Import into each module header
//----------------------------------------

`include "exec_cfg.svh"

package exec_pkg;

  typedef logic [`EXEC_ADDR_BITS-1:0]         addr_t;     // Program counter
  typedef logic [`EXEC_DATA_BITS-1:0]         data_t;     // Operand or result
  typedef logic [`EXEC_SEQ_BITS-1:0]          seq_t;      // Issue order tag
  typedef logic [$clog2(`EXEC_NUM_REGS)-1:0]  reg_idx_t;  // Register index

  // Micro-ops understood by the ALU
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,   // Shift by op2[4:0]
    OP_SRL,   // Logical, shift by op2[4:0]
    OP_SLT,   // Signed compare, result 1 or 0
    OP_ADDI   // op2 carries the immediate
  } rv_uop;

endpackage

// ==== rtl/exec_top.sv ====
//----------------------------------------
// Execute slice top, issue to ALU to writeback
// Takes decoded uops and commits results in order
//----------------------------------------

`timescale 1ns/10ps

module exec_top
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Decoded uop input
  input  logic     in_val,
  output logic     in_rdy,
  input  addr_t    in_pc,
  input  rv_uop    in_uop,
  input  reg_idx_t in_rs1,
  input  reg_idx_t in_rs2,
  input  data_t    in_imm,
  input  reg_idx_t in_waddr,

  // Commit output
  output logic     commit_val,
  input  logic     commit_rdy,
  output addr_t    commit_pc,
  output seq_t     commit_seq_num,
  output reg_idx_t commit_waddr,
  output data_t    commit_wdata
);

  //----------------------------------------
  // Stage wiring
  //----------------------------------------

  // Issue to ALU
  logic     d_val;
  logic     d_rdy;
  addr_t    d_pc;
  seq_t     d_seq_num;
  data_t    d_op1;
  data_t    d_op2;
  reg_idx_t d_waddr;
  rv_uop    d_uop;

  // ALU to writeback
  logic     w_val;
  logic     w_rdy;
  addr_t    w_pc;
  seq_t     w_seq_num;
  reg_idx_t w_waddr;
  data_t    w_wdata;

  // Register file and scoreboard
  reg_idx_t rf_raddr1;
  reg_idx_t rf_raddr2;
  data_t    rf_rdata1;
  data_t    rf_rdata2;
  logic     rf_wen;
  reg_idx_t rf_waddr;
  data_t    rf_wdata;
  logic     sb_clr_en;
  reg_idx_t sb_clr_idx;

  issue_unit u_issue (
    .clk        (clk),
    .rst        (rst),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_pc      (in_pc),
    .in_uop     (in_uop),
    .in_rs1     (in_rs1),
    .in_rs2     (in_rs2),
    .in_imm     (in_imm),
    .in_waddr   (in_waddr),
    .d_val      (d_val),
    .d_rdy      (d_rdy),
    .d_pc       (d_pc),
    .d_seq_num  (d_seq_num),
    .d_op1      (d_op1),
    .d_op2      (d_op2),
    .d_waddr    (d_waddr),
    .d_uop      (d_uop),
    .rf_raddr1  (rf_raddr1),
    .rf_raddr2  (rf_raddr2),
    .rf_rdata1  (rf_rdata1),
    .rf_rdata2  (rf_rdata2),
    .sb_clr_en  (sb_clr_en),
    .sb_clr_idx (sb_clr_idx)
  );

  alu u_alu (
    .clk       (clk),
    .rst       (rst),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_pc      (w_pc),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata)
  );

  writeback_unit u_wb (
    .clk            (clk),
    .rst            (rst),
    .w_val          (w_val),
    .w_rdy          (w_rdy),
    .w_pc           (w_pc),
    .w_seq_num      (w_seq_num),
    .w_waddr        (w_waddr),
    .w_wdata        (w_wdata),
    .rf_wen         (rf_wen),
    .rf_waddr       (rf_waddr),
    .rf_wdata       (rf_wdata),
    .sb_clr_en      (sb_clr_en),
    .sb_clr_idx     (sb_clr_idx),
    .commit_val     (commit_val),
    .commit_rdy     (commit_rdy),
    .commit_pc      (commit_pc),
    .commit_seq_num (commit_seq_num),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata)
  );

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

endmodule

// ==== rtl/issue_unit.sv ====
//----------------------------------------
// Issue stage, reads operands and tags uops
// Stalls on scoreboard hazards, feeds the ALU
//----------------------------------------

`timescale 1ns/10ps

`include "exec_cfg.svh"

module issue_unit
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Decoded uops from outside
  input  logic     in_val,
  output logic     in_rdy,
  input  addr_t    in_pc,
  input  rv_uop    in_uop,
  input  reg_idx_t in_rs1,
  input  reg_idx_t in_rs2,
  input  data_t    in_imm,
  input  reg_idx_t in_waddr,

  // To the ALU
  output logic     d_val,
  input  logic     d_rdy,
  output addr_t    d_pc,
  output seq_t     d_seq_num,
  output data_t    d_op1,
  output data_t    d_op2,
  output reg_idx_t d_waddr,
  output rv_uop    d_uop,

  // Register file read ports
  output reg_idx_t rf_raddr1,
  output reg_idx_t rf_raddr2,
  input  data_t    rf_rdata1,
  input  data_t    rf_rdata2,

  // Scoreboard release from writeback
  input  logic     sb_clr_en,
  input  reg_idx_t sb_clr_idx
);

  //----------------------------------------
  // Hazard check
  //----------------------------------------

  logic [`EXEC_NUM_REGS-1:0] sb_q;      // One bit per pending destination
  logic [`EXEC_NUM_REGS-1:0] sb_next;
  seq_t                      seq_q;     // Next tag to hand out
  logic                      hazard;
  logic                      issue_xfer;

  // Bit 0 is never set, so index 0 never stalls
  assign hazard = sb_q[in_rs1] | sb_q[in_rs2] | sb_q[in_waddr];

  assign d_val      = in_val & ~hazard;  // No dependence on d_rdy
  assign in_rdy     = d_rdy & ~hazard;
  assign issue_xfer = in_val & in_rdy;

  //----------------------------------------
  // Operand fetch, pass-through to ALU
  //----------------------------------------

  assign rf_raddr1 = in_rs1;
  assign rf_raddr2 = in_rs2;

  assign d_pc      = in_pc;
  assign d_seq_num = seq_q;
  assign d_op1     = rf_rdata1;
  assign d_op2     = (in_uop == OP_ADDI) ? in_imm : rf_rdata2;  // Immediate form
  assign d_waddr   = in_waddr;
  assign d_uop     = in_uop;

  //----------------------------------------
  // Scoreboard and sequence counter
  //----------------------------------------

  always_comb begin
    sb_next = sb_q;
    if (sb_clr_en) begin
      sb_next[sb_clr_idx] = 1'b0;
    end
    // Set after clear, a new producer of the same reg wins
    if (issue_xfer && (in_waddr != '0)) begin
      sb_next[in_waddr] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sb_q  <= '0;
      seq_q <= '0;
    end else begin
      sb_q <= sb_next;
      if (issue_xfer) begin
        seq_q <= seq_q + 1'b1;   // Wraps modulo 32
      end
    end
  end

endmodule

// ==== rtl/reg_file.sv ====
//----------------------------------------
// Architectural register file
// Two combinational reads, one write per edge
//----------------------------------------

`timescale 1ns/10ps

`include "exec_cfg.svh"

module reg_file
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  data_t    wdata,
  output data_t    rdata1,
  output data_t    rdata2
);

  data_t regs [`EXEC_NUM_REGS];

  // Writes land on the edge, register 0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
        regs[i] <= '0;   // Architectural state starts at zero
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads, no write forwarding
  // Dependent micro-ops wait on the scoreboard instead
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/writeback_unit.sv ====
//----------------------------------------
// Writeback stage, updates RF and scoreboard
// Holds each retired uop in a commit register
//----------------------------------------

`timescale 1ns/10ps

module writeback_unit
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // From the ALU
  input  logic     w_val,
  output logic     w_rdy,
  input  addr_t    w_pc,
  input  seq_t     w_seq_num,
  input  reg_idx_t w_waddr,
  input  data_t    w_wdata,

  // Register file write and scoreboard release
  output logic     rf_wen,
  output reg_idx_t rf_waddr,
  output data_t    rf_wdata,
  output logic     sb_clr_en,
  output reg_idx_t sb_clr_idx,

  // Commit ports
  output logic     commit_val,
  input  logic     commit_rdy,
  output addr_t    commit_pc,
  output seq_t     commit_seq_num,
  output reg_idx_t commit_waddr,
  output data_t    commit_wdata
);

  logic w_xfer;

  assign w_rdy  = ~commit_val | commit_rdy;   // Room once the old entry leaves
  assign w_xfer = w_val & w_rdy;

  // Same-edge pulses, RF ignores writes to reg 0
  assign rf_wen     = w_xfer;
  assign rf_waddr   = w_waddr;
  assign rf_wdata   = w_wdata;
  assign sb_clr_en  = w_xfer;
  assign sb_clr_idx = w_waddr;

  //----------------------------------------
  // Commit register
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_val <= 1'b0;
    end else if (w_xfer) begin
      commit_val <= 1'b1;
    end else if (commit_rdy) begin
      commit_val <= 1'b0;   // Drained without a refill
    end
  end

  // Holds under back-pressure, w_rdy is low then
  always_ff @(posedge clk) begin
    if (w_xfer) begin
      commit_pc      <= w_pc;
      commit_seq_num <= w_seq_num;
      commit_waddr   <= w_waddr;
      commit_wdata   <= w_wdata;
    end
  end

endmodule
